// ==== build.f ====
hdl/wb_pkg.sv
hdl/load_align.sv
hdl/wb_select.sv
hdl/reg_file.sv
hdl/commit_filter.sv
hdl/wb_top.sv
tb/wb_top_assert.sv
tb/tb_wb_top.sv

// ==== hdl/commit_filter.sv ====
/*
  Registered commit record for the retirement monitor, one cycle after the strobe.
  The previous order is remembered only across back-to-back strobes. Any idle
  cycle reloads order_none, so a repeat after a gap commits again.
  Record fields follow every strobe, including suppressed duplicates.
*/
`timescale 1ns/100ps
`default_nettype none

module commit_filter (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   logic              wb_valid,
    input  wire   wb_pkg::order_t    order,
    input  wire   wb_pkg::word_t     pc,
    input  wire   wb_pkg::reg_addr_t rd,
    input  wire   wb_pkg::word_t     rd_wdata,
    output logic                     commit_valid,
    output wb_pkg::order_t           commit_order,
    output wb_pkg::word_t            commit_pc,
    output wb_pkg::reg_addr_t        commit_rd,
    output wb_pkg::word_t            commit_wdata
);

    import wb_pkg::*;

    order_t prev_order;  // order of the strobe in the previous cycle
    logic   is_new;

    assign is_new = (order != prev_order);

    // duplicate tracker
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_order <= order_none;
        end else if (!wb_valid) begin
            prev_order <= order_none;  // gap breaks the back-to-back chain
        end else begin
            prev_order <= order;
        end
    end

    // single cycle valid pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= wb_valid && is_new;
        end
    end

    // record fields, held until the next strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_order <= '0;
            commit_pc    <= '0;
            commit_rd    <= '0;
            commit_wdata <= '0;
        end else if (wb_valid) begin
            commit_order <= order;
            commit_pc    <= pc;
            commit_rd    <= rd;
            commit_wdata <= rd_wdata;  // zero for stores
        end
    end

endmodule : commit_filter

`default_nettype wire

// ==== hdl/load_align.sv ====
/*
  Load data alignment for byte, halfword and word loads.
  Purely combinational. A halfword at offset 1 or 3 is never issued by the
  pipeline and gives no defined result. Non-load selects pass the raw word.
*/
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  wire   wb_pkg::word_t   mem_rdata,
    input  wire   logic [1:0]      mem_offset,  // address bits 1:0
    input  wire   wb_pkg::wb_sel_e sel,
    output wb_pkg::word_t          load_value
);

    import wb_pkg::*;

    word_t      shifted;    // addressed byte/halfword moved down to bit 0
    logic [4:0] shift_amt;

    assign shift_amt = {mem_offset, 3'b000};
    assign shifted   = mem_rdata >> shift_amt;

    always_comb begin
        unique case (sel)
            lb: begin
                load_value = {{24{shifted[7]}}, shifted[7:0]};  // sign extend
            end
            lbu: begin
                load_value = {24'b0, shifted[7:0]};
            end
            lh: begin
                load_value = {{16{shifted[15]}}, shifted[15:0]};
            end
            lhu: begin
                load_value = {16'b0, shifted[15:0]};
            end
            lw: begin
                load_value = mem_rdata;  // word loads are always aligned
            end
            default: begin
                load_value = mem_rdata;  // not a load, wb_select ignores it
            end
        endcase
    end

endmodule : load_align

`default_nettype wire

// ==== hdl/reg_file.sv ====
/*
  Integer register file, x1..x31 with x0 hard-wired to zero.
  Two combinational read ports for decode. A write in the current cycle is
  bypassed to a matching read, so decode needs no stall on writeback.
*/
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   logic              wr_en,
    input  wire   wb_pkg::reg_addr_t wr_addr,
    input  wire   wb_pkg::word_t     wr_data,
    input  wire   wb_pkg::reg_addr_t rs1_addr,
    input  wire   wb_pkg::reg_addr_t rs2_addr,
    output wb_pkg::word_t            rs1_data,
    output wb_pkg::word_t            rs2_data
);

    import wb_pkg::*;

    word_t regs [1:num_regs-1];  // no storage for x0

    // one read port, bypass has priority over storage
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && (wr_addr == addr)) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // writes to x0 dropped
        end
    end

    // re-evaluated on storage and write-port changes, not only the address
    always_comb begin
        rs1_data = read_port(rs1_addr);
    end

    always_comb begin
        rs2_data = read_port(rs2_addr);
    end

endmodule : reg_file

`default_nettype wire

// ==== hdl/wb_pkg.sv ====
/*
  Shared types and constants for the RV32I writeback subsystem.
  wb_sel_e follows the memory-stage control encoding, so values 9 to 15 are unused.
  order_none marks "no previous commit". A real order of all ones is therefore
  never reported as a first commit.
*/
`default_nettype none

package wb_pkg;

    localparam int word_w     = 32;
    localparam int order_w    = 64;  // rvfi style retirement order
    localparam int num_regs   = 32;
    localparam int reg_addr_w = $clog2(num_regs);
    localparam int wb_sel_w   = 4;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [order_w-1:0]    order_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // sentinel for the remembered order, loaded by reset and by idle cycles
    localparam order_t order_none = {order_w{1'b1}};

    // writeback source select, driven by the memory stage control word
    typedef enum logic [wb_sel_w-1:0] {
        alu_out  = 4'd0,
        br_en    = 4'd1,  // compare result, zero extended
        u_imm    = 4'd2,
        lw       = 4'd3,
        pc_plus4 = 4'd4,  // link address for jal / jalr
        lb       = 4'd5,
        lbu      = 4'd6,
        lh       = 4'd7,
        lhu      = 4'd8
    } wb_sel_e;

endpackage : wb_pkg

`default_nettype wire

// ==== hdl/wb_select.sv ====
/*
  Writeback source multiplexer.
  All load encodings take the aligned value from load_align unchanged.
  A store yields zero so the commit record carries no register data.
*/
`timescale 1ns/100ps
`default_nettype none

module wb_select (
    input  wire   wb_pkg::wb_sel_e sel,
    input  wire   wb_pkg::word_t   alu_result,
    input  wire   logic            br_result,
    input  wire   wb_pkg::word_t   u_imm,
    input  wire   wb_pkg::word_t   pc,
    input  wire   wb_pkg::word_t   load_value,
    input  wire   logic            is_store,
    output wb_pkg::word_t          wb_data
);

    import wb_pkg::*;

    word_t mux_value;   // selected source before store zeroing
    word_t link_addr;

    assign link_addr = pc + word_t'(4);

    always_comb begin
        unique case (sel)
            alu_out: begin
                mux_value = alu_result;
            end
            br_en: begin
                mux_value = {31'b0, br_result};
            end
            wb_pkg::u_imm: begin
                mux_value = u_imm;  // port shares the name with the select value
            end
            pc_plus4: begin
                mux_value = link_addr;
            end
            lw, lb, lbu, lh, lhu: begin
                mux_value = load_value;  // width handled in load_align
            end
            default: begin
                mux_value = alu_result;
            end
        endcase
    end

    assign wb_data = is_store ? '0 : mux_value;

endmodule : wb_select

`default_nettype wire

// ==== hdl/wb_top.sv ====
/*
  Writeback subsystem of a five-stage RV32I pipeline.
  Inputs are sampled only while wb_valid is high. There is no back-pressure.
  Register write lands on the strobe edge. The commit record follows one cycle later.
  A duplicate order still rewrites the register file with the same value.
*/
`timescale 1ns/100ps
`default_nettype none

module wb_top (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   logic              wb_valid,
    input  wire   wb_pkg::order_t    order,
    input  wire   wb_pkg::word_t     pc,
    input  wire   wb_pkg::wb_sel_e   sel,
    input  wire   wb_pkg::word_t     alu_result,
    input  wire   logic              br_result,
    input  wire   wb_pkg::word_t     u_imm,
    input  wire   wb_pkg::word_t     mem_rdata,
    input  wire   logic [1:0]        mem_offset,
    input  wire   wb_pkg::reg_addr_t rd,
    input  wire   logic              ld_reg,
    input  wire   logic              is_store,
    input  wire   wb_pkg::reg_addr_t rs1_addr,
    input  wire   wb_pkg::reg_addr_t rs2_addr,
    output wb_pkg::word_t            rs1_data,
    output wb_pkg::word_t            rs2_data,
    output logic                     commit_valid,
    output wb_pkg::order_t           commit_order,
    output wb_pkg::word_t            commit_pc,
    output wb_pkg::reg_addr_t        commit_rd,
    output wb_pkg::word_t            commit_wdata
);

    import wb_pkg::*;

    word_t load_value;  // aligned and extended load data
    word_t wb_data;     // final writeback value
    logic  reg_wr_en;

    assign reg_wr_en = wb_valid && ld_reg;

    load_align load_align_inst (
        .mem_rdata  (mem_rdata),
        .mem_offset (mem_offset),
        .sel        (sel),
        .load_value (load_value)
    );

    wb_select wb_select_inst (
        .sel        (sel),
        .alu_result (alu_result),
        .br_result  (br_result),
        .u_imm      (u_imm),
        .pc         (pc),
        .load_value (load_value),
        .is_store   (is_store),
        .wb_data    (wb_data)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (reg_wr_en),
        .wr_addr  (rd),
        .wr_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    commit_filter commit_filter_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_valid     (wb_valid),
        .order        (order),
        .pc           (pc),
        .rd           (rd),
        .rd_wdata     (wb_data),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

endmodule : wb_top

`default_nettype wire

// ==== tb/tb_wb_top.sv ====
/*
  Testbench for wb_top with a software model of registers and commit record.
  Inputs change on the falling edge. Registered outputs are checked there,
  read ports 5 ns later while the strobe inputs are steady.
  Random operands come from $random with seed 13.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top;

    import wb_pkg::*;

    localparam int test_cycles    = 200;  // rough length of all tests
    localparam int timeout_cycles = 10 * test_cycles;

    logic      clk;
    logic      arst_n;
    logic      wb_valid;
    order_t    order;
    word_t     pc;
    wb_sel_e   sel;
    word_t     alu_result;
    logic      br_result;
    word_t     u_imm;
    word_t     mem_rdata;
    logic [1:0] mem_offset;
    reg_addr_t rd;
    logic      ld_reg;
    logic      is_store;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      commit_valid;
    order_t    commit_order;
    word_t     commit_pc;
    reg_addr_t commit_rd;
    word_t     commit_wdata;

    // operands and read addresses for the next driven cycle
    word_t      op_pc;
    word_t      op_alu;
    logic       op_br;
    word_t      op_uimm;
    word_t      op_rdata;
    logic [1:0] op_off;
    reg_addr_t  ra1;
    reg_addr_t  ra2;
    logic       rst_req;
    order_t     ord_cnt;

    // reference model
    word_t     mregs [num_regs];
    logic      exp_valid;
    order_t    exp_order;
    word_t     exp_pc;
    reg_addr_t exp_rd;
    word_t     exp_wdata;
    order_t    last_order;

    string cur_test;
    int    seed;
    int    err_count = 0;
    int    test_err_start;
    int    pass_tests = 0;
    int    fail_tests = 0;
    int    commits_seen = 0;
    int    cycles = 0;

    wb_top wb_top_inst (.*);

    bind wb_top wb_top_assert wb_top_assert_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_valid     (wb_valid),
        .order        (order),
        .commit_valid (commit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Error in %s, %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    // value the plan's rules give for the current operands
    function automatic word_t expected_wb(input wb_sel_e s, input logic st);
        word_t w;
        int    lsb;
        lsb = 8 * int'(op_off);
        case (s)
            alu_out:       w = op_alu;
            br_en:         w = {31'h0, op_br};
            wb_pkg::u_imm: w = op_uimm;
            pc_plus4:      w = op_pc + 32'd4;
            lb:            w = {{24{op_rdata[lsb+7]}}, op_rdata[lsb +: 8]};
            lbu:           w = {24'h0, op_rdata[lsb +: 8]};
            lh:            w = {{16{op_rdata[lsb+15]}}, op_rdata[lsb +: 16]};
            lhu:           w = {16'h0, op_rdata[lsb +: 16]};
            default:       w = op_rdata;  // lw
        endcase
        if (st) begin
            w = '0;
        end
        return w;
    endfunction

    function automatic word_t read_expect(input reg_addr_t a, input logic wr,
                                          input reg_addr_t wa, input word_t val);
        if (a == '0) begin
            return '0;
        end
        if (wr && (wa == a)) begin
            return val;  // same-cycle bypass
        end
        return mregs[a];
    endfunction

    task automatic clear_model;
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end
        exp_valid  = 1'b0;
        exp_order  = '0;
        exp_pc     = '0;
        exp_rd     = '0;
        exp_wdata  = '0;
        last_order = order_none;
    endtask

    task automatic check_commit;
        check_val("commit_valid", 64'(exp_valid), 64'(commit_valid));
        check_val("commit_order", exp_order, commit_order);
        check_val("commit_pc", 64'(exp_pc), 64'(commit_pc));
        check_val("commit_rd", 64'(exp_rd), 64'(commit_rd));
        check_val("commit_wdata", 64'(exp_wdata), 64'(commit_wdata));
        if (commit_valid === 1'b1) begin
            commits_seen++;
        end
    endtask

    // one clock cycle: check, drive, check reads, advance the model
    task automatic run_cycle(input logic v, input order_t o, input wb_sel_e s,
                             input reg_addr_t r, input logic ld, input logic st);
        word_t val;
        @(negedge clk);
        check_commit();
        arst_n     = rst_req;
        wb_valid   = v;
        order      = o;
        sel        = s;
        rd         = r;
        ld_reg     = ld;
        is_store   = st;
        pc         = op_pc;
        alu_result = op_alu;
        br_result  = op_br;
        u_imm      = op_uimm;
        mem_rdata  = op_rdata;
        mem_offset = op_off;
        rs1_addr   = ra1;
        rs2_addr   = ra2;
        if (!rst_req) begin
            clear_model();  // async reset clears at once
        end
        val = expected_wb(s, st);
        #5;
        check_val("rs1_data", 64'(read_expect(ra1, v && ld, r, val)), 64'(rs1_data));
        check_val("rs2_data", 64'(read_expect(ra2, v && ld, r, val)), 64'(rs2_data));
        exp_valid = v && (o != last_order);
        if (v) begin
            exp_order  = o;
            exp_pc     = op_pc;
            exp_rd     = r;
            exp_wdata  = val;
            last_order = o;
        end else begin
            last_order = order_none;
        end
        if (v && ld && (r != '0)) begin
            mregs[r] = val;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            run_cycle(1'b0, '0, alu_out, '0, 1'b0, 1'b0);
        end
    endtask

    // rep reuses the previous order, as a stalled pipeline would
    task automatic retire(input logic rep, input wb_sel_e s, input reg_addr_t r,
                          input logic ld, input logic st);
        if (!rep) begin
            ord_cnt++;
        end
        ra2 = r;
        run_cycle(1'b1, ord_cnt, s, r, ld, st);
        ra1 = r;  // read back from storage next cycle
    endtask

    task automatic new_operands;
        op_pc    = $random(seed) & 32'hffff_fffc;
        op_alu   = $random(seed);
        op_br    = $random(seed) & 1;
        op_uimm  = $random(seed) & 32'hffff_f000;
        op_rdata = $random(seed);
        op_off   = $random(seed) & 3;
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test;
        if (err_count == test_err_start) begin
            pass_tests++;
            $display("test %s: pass", cur_test);
        end else begin
            fail_tests++;
            $display("test %s: FAIL, %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    task automatic test_source_select;
        wb_sel_e srcs [4];
        srcs = '{alu_out, br_en, wb_pkg::u_imm, pc_plus4};
        begin_test("source_select");
        for (int i = 0; i < 4; i++) begin
            new_operands();
            retire(1'b0, srcs[i], reg_addr_t'(i + 1), 1'b1, 1'b0);
            idle(1);
        end
        end_test();
    endtask

    task automatic test_load_extend;
        wb_sel_e loads [5];
        loads = '{lb, lbu, lh, lhu, lw};
        begin_test("load_extend");
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                if (((loads[k] == lh) || (loads[k] == lhu)) && off[0]) begin
                    continue;  // misaligned halfword
                end
                if ((loads[k] == lw) && (off != 0)) begin
                    continue;
                end
                new_operands();
                op_rdata = 32'h8080_8080 | $random(seed);  // sign bit in every byte
                op_off   = 2'(off);
                retire(1'b0, loads[k], reg_addr_t'(8 + k), 1'b1, 1'b0);
                idle(1);
            end
        end
        end_test();
    endtask

    task automatic test_zero_bypass;
        begin_test("zero_and_bypass");
        new_operands();
        retire(1'b0, alu_out, 5'd0, 1'b1, 1'b0);
        idle(1);
        new_operands();
        retire(1'b0, alu_out, 5'd20, 1'b1, 1'b0);
        new_operands();
        retire(1'b0, alu_out, 5'd20, 1'b1, 1'b0);  // newer value wins the bypass
        idle(1);
        end_test();
    endtask

    task automatic test_store;
        begin_test("store");
        new_operands();
        retire(1'b0, alu_out, 5'd9, 1'b1, 1'b0);
        idle(1);
        new_operands();
        retire(1'b0, alu_out, 5'd9, 1'b0, 1'b1);
        new_operands();
        retire(1'b0, lw, 5'd9, 1'b0, 1'b1);
        idle(1);
        end_test();
    endtask

    task automatic test_duplicate;
        int base;
        begin_test("duplicate");
        base = commits_seen;
        new_operands();
        retire(1'b0, alu_out, 5'd11, 1'b1, 1'b0);
        retire(1'b1, alu_out, 5'd11, 1'b1, 1'b0);
        idle(2);
        check_val("commits after repeat", 64'(base + 1), 64'(commits_seen));
        retire(1'b1, alu_out, 5'd11, 1'b1, 1'b0);  // same order after a gap
        new_operands();
        retire(1'b0, alu_out, 5'd12, 1'b1, 1'b0);
        idle(1);
        check_val("commits after gap", 64'(base + 3), 64'(commits_seen));
        end_test();
    endtask

    task automatic test_reset;
        begin_test("reset_state");
        rst_req = 1'b0;
        repeat (3) begin
            ra1 = reg_addr_t'($random(seed));
            ra2 = reg_addr_t'($random(seed));
            idle(1);
        end
        rst_req = 1'b1;
        repeat (2) begin
            ra1 = reg_addr_t'($random(seed));
            ra2 = reg_addr_t'($random(seed));
            idle(1);
        end
        end_test();
    endtask

    initial begin
        int a_errs;
        seed       = 13;
        ord_cnt    = '0;
        cur_test   = "initial_reset";
        arst_n     = 1'b0;
        rst_req    = 1'b0;
        wb_valid   = 1'b0;
        order      = '0;
        pc         = '0;
        sel        = alu_out;
        alu_result = '0;
        br_result  = 1'b0;
        u_imm      = '0;
        mem_rdata  = '0;
        mem_offset = 2'b00;
        rd         = '0;
        ld_reg     = 1'b0;
        is_store   = 1'b0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        ra1        = '0;
        ra2        = '0;
        new_operands();
        clear_model();
        idle(2);
        rst_req = 1'b1;  // released on the third falling edge
        idle(1);
        test_source_select();
        test_load_extend();
        test_zero_bypass();
        test_store();
        test_duplicate();
        test_reset();
        a_errs = wb_top_inst.wb_top_assert_inst.assert_errors;
        $display("passed tests: %0d, failed tests: %0d, concurrent assertion failures: %0d",
                 pass_tests, fail_tests, a_errs);
        if ((err_count == 0) && (a_errs == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_wb_top

`default_nettype wire

// ==== tb/wb_top_assert.sv ====
/*
  Concurrent checks on the commit timing of wb_top, attached with bind.
  Assumes order_none is never a real order, so a strobe after an idle cycle
  always commits. Failures are counted in assert_errors for the run summary.
*/
`timescale 1ns/100ps
`default_nettype none

module wb_top_assert (
    input wire logic           clk,
    input wire logic           arst_n,
    input wire logic           wb_valid,
    input wire wb_pkg::order_t order,
    input wire logic           commit_valid
);

    int assert_errors = 0;  // read by the testbench summary

    // no commit without a strobe one cycle earlier
    commit_needs_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_valid |-> $past(wb_valid)
    ) else begin
        $error("commit_valid high without a strobe in the previous cycle");
        assert_errors++;
    end

    // a strobe that is not a back-to-back repeat of the same order
    new_order_commits: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_valid && !($past(wb_valid) && (order == $past(order)))) |=> commit_valid
    ) else begin
        $error("new order did not raise commit_valid in the next cycle");
        assert_errors++;
    end

    reset_clears_commit: assert property (
        @(posedge clk)
        !arst_n |-> !commit_valid
    ) else begin
        $error("commit_valid high while reset is asserted");
        assert_errors++;
    end

endmodule : wb_top_assert

`default_nettype wire
